//--- include/soc_settings.svh
`ifndef SOC_SETTINGS_SVH
`define SOC_SETTINGS_SVH

// Bus widths
`define SOC_ADDR_W 32
`define SOC_DATA_W 32
`define SOC_STRB_W (`SOC_DATA_W / 8)

// SRAM depth in words
`define SOC_SRAM_WORDS 1024

`define SOC_GPIO_OUTPUTS 4

// Values of address bits 31:28 for each device
`define SOC_SRAM_REGION 4'h0
`define SOC_PLATFORM_REGION 4'h2

`endif

//--- design/soc_pkg.sv
`include "soc_settings.svh"

package soc_pkg;

    // Request channel payload
    typedef struct packed {
        logic [`SOC_ADDR_W-1:0] addr;
        logic                   write;
        logic [`SOC_DATA_W-1:0] wdata;
        logic [`SOC_STRB_W-1:0] strb;
    } bus_req_t;

    // Response channel payload, err marks a decode or offset miss
    typedef struct packed {
        logic [`SOC_DATA_W-1:0] rdata;
        logic                   err;
    } bus_rsp_t;

    // Device chosen by the address decode
    typedef enum logic [1:0] {
        DEV_NONE,
        DEV_SRAM,
        DEV_PLATFORM
    } dev_sel_t;

endpackage

//--- design/bus_slice.sv
`timescale 1ns/1ps

module bus_slice #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst_n,

    input  payload_t in_data,
    input  logic     in_valid,
    output logic     in_ready,

    output payload_t out_data,
    output logic     out_valid,
    input  logic     out_ready
);

    // Accept when empty or when the held entry leaves this cycle
    assign in_ready = !out_valid || out_ready;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else if (in_ready) begin
            out_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            out_data <= in_data;
        end
    end

endmodule

//--- design/bus_arbiter.sv
`timescale 1ns/1ps
`include "soc_settings.svh"

module bus_arbiter (
    input  logic              clk,
    input  logic              rst_n,

    // Instruction fetch master
    input  soc_pkg::bus_req_t fetch_req,
    input  logic              fetch_req_valid,
    output logic              fetch_req_ready,
    output soc_pkg::bus_rsp_t fetch_rsp,
    output logic              fetch_rsp_valid,
    input  logic              fetch_rsp_ready,

    // Data master
    input  soc_pkg::bus_req_t data_req,
    input  logic              data_req_valid,
    output logic              data_req_ready,
    output soc_pkg::bus_rsp_t data_rsp,
    output logic              data_rsp_valid,
    input  logic              data_rsp_ready,

    // Devices
    output soc_pkg::bus_req_t dev_req,
    output logic              sram_sel,
    output logic              platform_sel,
    input  soc_pkg::bus_rsp_t sram_rsp,
    input  logic              sram_rsp_valid,
    input  soc_pkg::bus_rsp_t platform_rsp,
    input  logic              platform_rsp_valid
);
    import soc_pkg::*;

    typedef enum logic [1:0] {
        ARB_IDLE,
        ARB_WAIT,
        ARB_HOLD
    } arb_state_t;

    arb_state_t state;
    // Master of the current or most recent transaction, 1 for data
    logic       grant_data;
    logic       pick_data;
    logic       start;
    logic       dev_done;
    logic       rsp_taken;
    dev_sel_t   dev_sel;
    dev_sel_t   dev_sel_q;
    bus_rsp_t   rsp_q;

    function automatic dev_sel_t decode(input logic [`SOC_ADDR_W-1:0] addr);
        case (addr[`SOC_ADDR_W-1 -: 4])
            `SOC_SRAM_REGION:     decode = DEV_SRAM;
            `SOC_PLATFORM_REGION: decode = DEV_PLATFORM;
            default:              decode = DEV_NONE;
        endcase
    endfunction

    // Round robin, the master not served last wins a tie
    assign pick_data = data_req_valid && (!fetch_req_valid || !grant_data);
    assign start     = (state == ARB_IDLE) && (fetch_req_valid || data_req_valid);

    assign dev_req = pick_data ? data_req : fetch_req;
    assign dev_sel = decode(dev_req.addr);

    assign fetch_req_ready = (state == ARB_IDLE) && fetch_req_valid && !pick_data;
    assign data_req_ready  = (state == ARB_IDLE) && pick_data;

    assign sram_sel     = start && (dev_sel == DEV_SRAM);
    assign platform_sel = start && (dev_sel == DEV_PLATFORM);

    always_comb begin
        case (dev_sel_q)
            DEV_SRAM:     dev_done = sram_rsp_valid;
            DEV_PLATFORM: dev_done = platform_rsp_valid;
            default:      dev_done = 1'b1;
        endcase
    end

    assign rsp_taken = grant_data ? data_rsp_ready : fetch_rsp_ready;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state      <= ARB_IDLE;
            grant_data <= 1'b1;
        end else begin
            case (state)
                ARB_IDLE: begin
                    if (start) begin
                        state      <= ARB_WAIT;
                        grant_data <= pick_data;
                    end
                end
                ARB_WAIT: begin
                    if (dev_done) begin
                        state <= ARB_HOLD;
                    end
                end
                ARB_HOLD: begin
                    if (rsp_taken) begin
                        state <= ARB_IDLE;
                    end
                end
                default: state <= ARB_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            dev_sel_q <= dev_sel;
        end
        if (state == ARB_WAIT && dev_done) begin
            case (dev_sel_q)
                DEV_SRAM:     rsp_q <= sram_rsp;
                DEV_PLATFORM: rsp_q <= platform_rsp;
                // Unmapped region
                default:      rsp_q <= '{rdata: '0, err: 1'b1};
            endcase
        end
    end

    assign fetch_rsp       = rsp_q;
    assign data_rsp        = rsp_q;
    assign fetch_rsp_valid = (state == ARB_HOLD) && !grant_data;
    assign data_rsp_valid  = (state == ARB_HOLD) && grant_data;

endmodule

//--- design/soc_sram.sv
`timescale 1ns/1ps
`include "soc_settings.svh"

module soc_sram (
    input  logic              clk,

    input  logic              sel,
    input  soc_pkg::bus_req_t req,
    output soc_pkg::bus_rsp_t rsp,
    output logic              rsp_valid
);

    localparam int IDX_W = $clog2(`SOC_SRAM_WORDS);

    logic [`SOC_DATA_W-1:0] mem [`SOC_SRAM_WORDS];
    logic [IDX_W-1:0]       idx;

    // Word index, upper bits of the region alias
    assign idx = req.addr[IDX_W+1:2];

    // Strobe follows sel, so it is low while the arbiter is held in reset
    always_ff @(posedge clk) begin
        rsp_valid <= sel;
    end

    // Old word is returned, also on a write
    always_ff @(posedge clk) begin
        if (sel) begin
            rsp.rdata <= mem[idx];
            rsp.err   <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (sel && req.write) begin
            for (int b = 0; b < `SOC_STRB_W; b++) begin
                if (req.strb[b]) begin
                    mem[idx][b*8 +: 8] <= req.wdata[b*8 +: 8];
                end
            end
        end
    end

endmodule

//--- design/soc_platform.sv
`timescale 1ns/1ps
`include "soc_settings.svh"

module soc_platform (
    input  logic                         clk,
    input  logic                         rst_n,

    input  logic                         sel,
    input  soc_pkg::bus_req_t            req,
    output soc_pkg::bus_rsp_t            rsp,
    output logic                         rsp_valid,

    input  logic                         mtime_tick,
    output logic                         mtime_int,
    output logic [`SOC_GPIO_OUTPUTS-1:0] gpio_outputs
);

    localparam int OFF_W = `SOC_ADDR_W - 4;

    localparam logic [OFF_W-1:0] OFF_MTIME_LO    = 'h00;
    localparam logic [OFF_W-1:0] OFF_MTIME_HI    = 'h04;
    localparam logic [OFF_W-1:0] OFF_MTIMECMP_LO = 'h08;
    localparam logic [OFF_W-1:0] OFF_MTIMECMP_HI = 'h0C;
    localparam logic [OFF_W-1:0] OFF_GPIO        = 'h10;

    logic [63:0]                  mtime;
    logic [63:0]                  mtimecmp;
    logic [OFF_W-1:0]             offset;
    logic                         wr;
    logic                         known;
    logic [`SOC_DATA_W-1:0]       rdata;

    assign offset = req.addr[OFF_W-1:0];
    assign wr     = sel && req.write;

    // Register read mux and offset check
    always_comb begin
        known = 1'b1;
        rdata = '0;
        case (offset)
            OFF_MTIME_LO:    rdata = mtime[31:0];
            OFF_MTIME_HI:    rdata = mtime[63:32];
            OFF_MTIMECMP_LO: rdata = mtimecmp[31:0];
            OFF_MTIMECMP_HI: rdata = mtimecmp[63:32];
            OFF_GPIO:        rdata[`SOC_GPIO_OUTPUTS-1:0] = gpio_outputs;
            default:         known = 1'b0;
        endcase
    end

    // Bus write beats the tick
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mtime <= '0;
        end else if (wr && offset == OFF_MTIME_LO) begin
            mtime[31:0] <= req.wdata;
        end else if (wr && offset == OFF_MTIME_HI) begin
            mtime[63:32] <= req.wdata;
        end else if (mtime_tick) begin
            mtime <= mtime + 64'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mtimecmp     <= '1;
            gpio_outputs <= '0;
        end else if (wr) begin
            if (offset == OFF_MTIMECMP_LO) mtimecmp[31:0] <= req.wdata;
            if (offset == OFF_MTIMECMP_HI) mtimecmp[63:32] <= req.wdata;
            if (offset == OFF_GPIO) gpio_outputs <= req.wdata[`SOC_GPIO_OUTPUTS-1:0];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mtime_int <= 1'b0;
            rsp_valid <= 1'b0;
        end else begin
            mtime_int <= (mtime >= mtimecmp);
            rsp_valid <= sel;
        end
    end

    // Writes and misses read back as zero
    always_ff @(posedge clk) begin
        if (sel) begin
            rsp.rdata <= (req.write || !known) ? '0 : rdata;
            rsp.err   <= !known;
        end
    end

endmodule

//--- design/soc_top.sv
`timescale 1ns/1ps
`include "soc_settings.svh"

module soc_top (
    input  logic                         clk,
    input  logic                         rst_n,

    // Instruction fetch master
    input  soc_pkg::bus_req_t            fetch_req,
    input  logic                         fetch_req_valid,
    output logic                         fetch_req_ready,
    output soc_pkg::bus_rsp_t            fetch_rsp,
    output logic                         fetch_rsp_valid,
    input  logic                         fetch_rsp_ready,

    // Data master
    input  soc_pkg::bus_req_t            data_req,
    input  logic                         data_req_valid,
    output logic                         data_req_ready,
    output soc_pkg::bus_rsp_t            data_rsp,
    output logic                         data_rsp_valid,
    input  logic                         data_rsp_ready,

    input  logic                         mtime_tick,
    output logic                         mtime_int,
    output logic [`SOC_GPIO_OUTPUTS-1:0] gpio_outputs
);
    import soc_pkg::*;

    // Slice to arbiter
    bus_req_t fetch_bus_req;
    logic     fetch_bus_req_valid;
    logic     fetch_bus_req_ready;
    bus_req_t data_bus_req;
    logic     data_bus_req_valid;
    logic     data_bus_req_ready;
    bus_rsp_t fetch_bus_rsp;
    logic     fetch_bus_rsp_valid;
    logic     fetch_bus_rsp_ready;
    bus_rsp_t data_bus_rsp;
    logic     data_bus_rsp_valid;
    logic     data_bus_rsp_ready;

    // Arbiter to devices
    bus_req_t dev_req;
    logic     sram_sel;
    logic     platform_sel;
    bus_rsp_t sram_rsp;
    logic     sram_rsp_valid;
    bus_rsp_t platform_rsp;
    logic     platform_rsp_valid;

    bus_slice #(.payload_t(bus_req_t)) fetch_req_slice (
        .clk, .rst_n,
        .in_data(fetch_req), .in_valid(fetch_req_valid), .in_ready(fetch_req_ready),
        .out_data(fetch_bus_req), .out_valid(fetch_bus_req_valid),
        .out_ready(fetch_bus_req_ready)
    );

    bus_slice #(.payload_t(bus_req_t)) data_req_slice (
        .clk, .rst_n,
        .in_data(data_req), .in_valid(data_req_valid), .in_ready(data_req_ready),
        .out_data(data_bus_req), .out_valid(data_bus_req_valid),
        .out_ready(data_bus_req_ready)
    );

    bus_slice #(.payload_t(bus_rsp_t)) fetch_rsp_slice (
        .clk, .rst_n,
        .in_data(fetch_bus_rsp), .in_valid(fetch_bus_rsp_valid),
        .in_ready(fetch_bus_rsp_ready),
        .out_data(fetch_rsp), .out_valid(fetch_rsp_valid), .out_ready(fetch_rsp_ready)
    );

    bus_slice #(.payload_t(bus_rsp_t)) data_rsp_slice (
        .clk, .rst_n,
        .in_data(data_bus_rsp), .in_valid(data_bus_rsp_valid),
        .in_ready(data_bus_rsp_ready),
        .out_data(data_rsp), .out_valid(data_rsp_valid), .out_ready(data_rsp_ready)
    );

    bus_arbiter sys_bus (
        .clk, .rst_n,
        .fetch_req(fetch_bus_req), .fetch_req_valid(fetch_bus_req_valid),
        .fetch_req_ready(fetch_bus_req_ready),
        .fetch_rsp(fetch_bus_rsp), .fetch_rsp_valid(fetch_bus_rsp_valid),
        .fetch_rsp_ready(fetch_bus_rsp_ready),
        .data_req(data_bus_req), .data_req_valid(data_bus_req_valid),
        .data_req_ready(data_bus_req_ready),
        .data_rsp(data_bus_rsp), .data_rsp_valid(data_bus_rsp_valid),
        .data_rsp_ready(data_bus_rsp_ready),
        .dev_req, .sram_sel, .platform_sel,
        .sram_rsp, .sram_rsp_valid,
        .platform_rsp, .platform_rsp_valid
    );

    // Region 0
    soc_sram sram (
        .clk,
        .sel(sram_sel), .req(dev_req), .rsp(sram_rsp), .rsp_valid(sram_rsp_valid)
    );

    // Region 2
    soc_platform platform (
        .clk, .rst_n,
        .sel(platform_sel), .req(dev_req), .rsp(platform_rsp),
        .rsp_valid(platform_rsp_valid),
        .mtime_tick, .mtime_int, .gpio_outputs
    );

endmodule

//--- verif/soc_tb_clock.sv
`timescale 1ns/1ps

module soc_tb_clock #(
    parameter int PERIOD_NS = 20
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

endmodule

//--- verif/soc_bus_checker.sv
`timescale 1ns/1ps

module soc_bus_checker (
    input logic              clk,
    input logic              rst_n,

    input logic              fetch_req_valid,
    input logic              fetch_req_ready,
    input soc_pkg::bus_rsp_t fetch_rsp,
    input logic              fetch_rsp_valid,
    input logic              fetch_rsp_ready,

    input logic              data_req_valid,
    input logic              data_req_ready,
    input soc_pkg::bus_rsp_t data_rsp,
    input logic              data_rsp_valid,
    input logic              data_rsp_ready,

    input logic              mtime_int
);

    // Read by the testbench summary
    int assert_failures = 0;

    // Response held with a stable payload until taken
    fetch_rsp_hold: assert property (@(posedge clk) disable iff (!rst_n)
        fetch_rsp_valid && !fetch_rsp_ready |=> fetch_rsp_valid && $stable(fetch_rsp))
    else begin
        assert_failures++;
        $error("fetch response dropped or changed before it was taken");
    end

    data_rsp_hold: assert property (@(posedge clk) disable iff (!rst_n)
        data_rsp_valid && !data_rsp_ready |=> data_rsp_valid && $stable(data_rsp))
    else begin
        assert_failures++;
        $error("data response dropped or changed before it was taken");
    end

    // Request valid into the arbiter held until accepted
    fetch_req_hold: assert property (@(posedge clk) disable iff (!rst_n)
        fetch_req_valid && !fetch_req_ready |=> fetch_req_valid)
    else begin
        assert_failures++;
        $error("fetch request valid fell before it was accepted");
    end

    data_req_hold: assert property (@(posedge clk) disable iff (!rst_n)
        data_req_valid && !data_req_ready |=> data_req_valid)
    else begin
        assert_failures++;
        $error("data request valid fell before it was accepted");
    end

    reset_int_low: assert property (@(posedge clk) !rst_n |=> !mtime_int)
    else begin
        assert_failures++;
        $error("mtime_int high while in reset");
    end

endmodule

// Request side watches the slice outputs toward the arbiter
bind soc_top soc_bus_checker bus_checker_i (
    .clk,
    .rst_n,
    .fetch_req_valid(fetch_bus_req_valid),
    .fetch_req_ready(fetch_bus_req_ready),
    .fetch_rsp,
    .fetch_rsp_valid,
    .fetch_rsp_ready,
    .data_req_valid(data_bus_req_valid),
    .data_req_ready(data_bus_req_ready),
    .data_rsp,
    .data_rsp_valid,
    .data_rsp_ready,
    .mtime_int
);

//--- verif/soc_tb.sv
`timescale 1ns/1ps
`include "soc_settings.svh"

module soc_tb;
    import soc_pkg::*;

    localparam int SRAM_SPAN   = 16;
    localparam int RAND_WRITES = 40;
    localparam int STREAM_LEN  = 100;
    localparam int UNMAPPED    = 8;
    localparam int BAD_OFFSETS = 4;
    localparam int GPIO_WRITES = 6;
    localparam int TICKS       = 50;
    localparam int TXN_COUNT   = 2 * (2 * SRAM_SPAN + RAND_WRITES) + 2 * STREAM_LEN
                               + UNMAPPED + BAD_OFFSETS + 2 * SRAM_SPAN + 3
                               + 2 * GPIO_WRITES + 7;
    localparam int CYCLE_LIMIT = 60 * TXN_COUNT + 2000;
    localparam int IDX_W       = $clog2(`SOC_SRAM_WORDS);
    localparam logic [31:0] SEED = 32'h22c8eb66;

    // Expected response, rdata unchecked while the model word is unknown
    typedef struct packed {
        bus_rsp_t rsp;
        logic     check_rdata;
    } exp_t;

    logic                         clk;
    logic                         rst_n = 1'b0;
    bus_req_t                     req [2] = '{default: '0};
    logic                         req_valid [2] = '{default: 1'b0};
    logic                         req_ready [2];
    bus_rsp_t                     rsp [2];
    logic                         rsp_valid [2];
    logic                         rsp_ready [2] = '{default: 1'b0};
    logic                         mtime_tick = 1'b0;
    logic                         mtime_int;
    logic [`SOC_GPIO_OUTPUTS-1:0] gpio_outputs;

    // Reference model state
    logic [`SOC_DATA_W-1:0]       sram_model [`SOC_SRAM_WORDS];
    logic [63:0]                  cmp_model = '1;
    logic [63:0]                  tick_total = '0;
    logic [`SOC_GPIO_OUTPUTS-1:0] gpio_model = '0;

    bus_req_t    pend_q [2][$];
    exp_t        exp_q [2][$];
    int          issued_count [2] = '{default: 0};
    int          sent_count [2] = '{default: 0};
    int          rsp_count [2] = '{default: 0};
    int          value_errors = 0;
    int          flow_errors = 0;
    int          cycles = 0;
    int          ticks_left = 0;
    logic        throttle = 1'b0;
    logic [31:0] stim_seed = SEED;
    logic [31:0] flow_seed = SEED ^ 32'h5bd1e995;

    soc_tb_clock clock_gen (.clk(clk));

    soc_top soc_top_i (
        .clk, .rst_n,
        .fetch_req(req[0]), .fetch_req_valid(req_valid[0]), .fetch_req_ready(req_ready[0]),
        .fetch_rsp(rsp[0]), .fetch_rsp_valid(rsp_valid[0]), .fetch_rsp_ready(rsp_ready[0]),
        .data_req(req[1]), .data_req_valid(req_valid[1]), .data_req_ready(req_ready[1]),
        .data_rsp(rsp[1]), .data_rsp_valid(rsp_valid[1]), .data_rsp_ready(rsp_ready[1]),
        .mtime_tick, .mtime_int, .gpio_outputs
    );

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] next_rand();
        stim_seed = xorshift(stim_seed);
        return stim_seed;
    endfunction

    function automatic string master_name(input int m);
        return (m == 0) ? "fetch" : "data";
    endfunction

    function automatic bus_req_t make_req(input logic [`SOC_ADDR_W-1:0] addr,
                                          input logic write,
                                          input logic [`SOC_DATA_W-1:0] wdata,
                                          input logic [`SOC_STRB_W-1:0] strb);
        bus_req_t r;
        r.addr  = addr;
        r.write = write;
        r.wdata = wdata;
        r.strb  = strb;
        return r;
    endfunction

    // Each master owns its own half of the SRAM, alias bits are random
    function automatic logic [31:0] sram_addr(input int m, input int w);
        logic [31:0] a;
        a = next_rand();
        a[31:28]      = `SOC_SRAM_REGION;
        a[IDX_W+1:2]  = IDX_W'(m * (`SOC_SRAM_WORDS / 2) + w);
        a[1:0]        = 2'b00;
        return a;
    endfunction

    function automatic logic [31:0] platform_addr(input logic [27:0] off);
        return {`SOC_PLATFORM_REGION, off};
    endfunction

    task automatic model_access(input bus_req_t r, output exp_t e);
        logic [27:0]            off;
        logic [IDX_W-1:0]       idx;
        logic [`SOC_DATA_W-1:0] old;
        off = r.addr[27:0];
        idx = r.addr[IDX_W+1:2];
        e.rsp.rdata   = '0;
        e.rsp.err     = 1'b0;
        e.check_rdata = 1'b1;
        case (r.addr[31:28])
            `SOC_SRAM_REGION: begin
                old           = sram_model[idx];
                e.rsp.rdata   = old;
                e.check_rdata = !$isunknown(old);
                if (r.write) begin
                    for (int b = 0; b < `SOC_STRB_W; b++) begin
                        if (r.strb[b]) begin
                            sram_model[idx][b*8 +: 8] = r.wdata[b*8 +: 8];
                        end
                    end
                end
            end
            `SOC_PLATFORM_REGION: begin
                case (off)
                    28'h00:  e.rsp.rdata = tick_total[31:0];
                    28'h04:  e.rsp.rdata = tick_total[63:32];
                    28'h08:  e.rsp.rdata = cmp_model[31:0];
                    28'h0C:  e.rsp.rdata = cmp_model[63:32];
                    28'h10:  e.rsp.rdata = `SOC_DATA_W'(gpio_model);
                    default: e.rsp.err = 1'b1;
                endcase
                // Write responses and misses carry zero
                if (r.write || e.rsp.err) begin
                    e.rsp.rdata = '0;
                end
                if (r.write) begin
                    case (off)
                        28'h00:  tick_total[31:0] = r.wdata;
                        28'h04:  tick_total[63:32] = r.wdata;
                        28'h08:  cmp_model[31:0] = r.wdata;
                        28'h0C:  cmp_model[63:32] = r.wdata;
                        28'h10:  gpio_model = r.wdata[`SOC_GPIO_OUTPUTS-1:0];
                        default: ;
                    endcase
                end
            end
            default: e.rsp.err = 1'b1;
        endcase
    endtask

    task automatic issue_access(input int m, input bus_req_t r);
        exp_t e;
        model_access(r, e);
        pend_q[m].push_back(r);
        exp_q[m].push_back(e);
        issued_count[m]++;
    endtask

    task automatic check_response(input int m, input bus_rsp_t got);
        exp_t e;
        rsp_count[m]++;
        if (exp_q[m].size() == 0) begin
            flow_errors++;
            $display("Response on the %s port with no request outstanding", master_name(m));
        end else begin
            e = exp_q[m].pop_front();
            assert (got.err === e.rsp.err) else begin
                value_errors++;
                $display("[FAIL] %s_rsp.err expected %h got %h",
                         master_name(m), e.rsp.err, got.err);
            end
            if (e.check_rdata) begin
                assert (got.rdata === e.rsp.rdata) else begin
                    value_errors++;
                    $display("[FAIL] %s_rsp.rdata expected %h got %h",
                             master_name(m), e.rsp.rdata, got.rdata);
                end
            end
        end
    endtask

    task automatic wait_idle();
        while (exp_q[0].size() != 0 || exp_q[1].size() != 0) begin
            @(negedge clk);
        end
    endtask

    task automatic check_gpio();
        assert (gpio_outputs === gpio_model) else begin
            value_errors++;
            $display("[FAIL] gpio_outputs expected %h got %h", gpio_model, gpio_outputs);
        end
    endtask

    task automatic check_interrupt();
        logic want;
        want = (tick_total >= cmp_model);
        assert (mtime_int === want) else begin
            value_errors++;
            $display("[FAIL] mtime_int expected %h got %h", want, mtime_int);
        end
    endtask

    task automatic finish_run();
        int checker_errors;
        checker_errors = soc_top_i.bus_checker_i.assert_failures;
        $display("Errors: value %0d, flow %0d, protocol %0d",
                 value_errors, flow_errors, checker_errors);
        if (value_errors == 0 && flow_errors == 0 && checker_errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    endtask

    // Request, response ready and tick drivers
    always @(posedge clk) begin
        flow_seed = xorshift(flow_seed);
        if (!rst_n) begin
            for (int m = 0; m < 2; m++) begin
                req_valid[m] <= 1'b0;
                rsp_ready[m] <= 1'b0;
            end
            mtime_tick <= 1'b0;
        end else begin
            for (int m = 0; m < 2; m++) begin
                if (req_valid[m] && req_ready[m]) begin
                    void'(pend_q[m].pop_front());
                    sent_count[m]++;
                end
                // A presented request stays put until accepted
                if (!req_valid[m] || req_ready[m]) begin
                    if (pend_q[m].size() != 0 && flow_seed[2*m +: 2] != 2'b00) begin
                        req[m]       <= pend_q[m][0];
                        req_valid[m] <= 1'b1;
                    end else begin
                        req_valid[m] <= 1'b0;
                    end
                end
                if (rsp_valid[m] && rsp_ready[m]) begin
                    check_response(m, rsp[m]);
                end
                rsp_ready[m] <= !throttle || flow_seed[8 + m];
            end
            if (ticks_left != 0 && flow_seed[12]) begin
                mtime_tick <= 1'b1;
                ticks_left--;
            end else begin
                mtime_tick <= 1'b0;
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            flow_errors++;
            $display("Run stopped at the cycle limit of %0d cycles", CYCLE_LIMIT);
            finish_run();
        end
    end

    task automatic sram_fill_check();
        logic [31:0] addr;
        logic [31:0] data;
        logic [3:0]  strb;
        for (int m = 0; m < 2; m++) begin
            for (int w = 0; w < SRAM_SPAN; w++) begin
                addr = sram_addr(m, w);
                data = next_rand();
                issue_access(m, make_req(addr, 1'b1, data, 4'hF));
            end
            for (int i = 0; i < RAND_WRITES; i++) begin
                addr = sram_addr(m, int'(next_rand() % SRAM_SPAN));
                data = next_rand();
                strb = 4'(next_rand());
                issue_access(m, make_req(addr, 1'b1, data, strb));
            end
            for (int w = 0; w < SRAM_SPAN; w++) begin
                addr = sram_addr(m, w);
                issue_access(m, make_req(addr, 1'b0, '0, '0));
            end
        end
        wait_idle();
    endtask

    task automatic stream_both();
        logic [31:0] rnd;
        logic [31:0] addr;
        logic [31:0] data;
        throttle = 1'b1;
        for (int i = 0; i < STREAM_LEN; i++) begin
            for (int m = 0; m < 2; m++) begin
                rnd  = next_rand();
                addr = sram_addr(m, int'(rnd[7:0] % SRAM_SPAN));
                data = next_rand();
                issue_access(m, make_req(addr, rnd[8], data, rnd[12:9]));
            end
        end
        wait_idle();
        throttle = 1'b0;
    endtask

    task automatic error_access();
        logic [31:0] rnd;
        logic [31:0] addr;
        logic [27:0] off;
        for (int i = 0; i < UNMAPPED; i++) begin
            rnd  = next_rand();
            addr = next_rand();
            // Step off the two mapped regions
            if (addr[31:28] == `SOC_SRAM_REGION || addr[31:28] == `SOC_PLATFORM_REGION) begin
                addr[31:28] = addr[31:28] + 4'h1;
            end
            issue_access(i % 2, make_req(addr, rnd[0], next_rand(), 4'hF));
        end
        for (int i = 0; i < BAD_OFFSETS; i++) begin
            rnd = next_rand();
            off = rnd[27:0];
            if (off < 28'h14) begin
                off = off + 28'h14;
            end
            issue_access(1, make_req(platform_addr(off), rnd[31], next_rand(), 4'hF));
        end
        wait_idle();
        for (int m = 0; m < 2; m++) begin
            for (int w = 0; w < SRAM_SPAN; w++) begin
                addr = sram_addr(m, w);
                issue_access(m, make_req(addr, 1'b0, '0, '0));
            end
        end
        issue_access(1, make_req(platform_addr(28'h10), 1'b0, '0, '0));
        issue_access(1, make_req(platform_addr(28'h08), 1'b0, '0, '0));
        issue_access(1, make_req(platform_addr(28'h0C), 1'b0, '0, '0));
        wait_idle();
    endtask

    task automatic gpio_write_read();
        logic [31:0] data;
        for (int i = 0; i < GPIO_WRITES; i++) begin
            data = next_rand();
            // Strobes are ignored by the platform block
            issue_access(i % 2, make_req(platform_addr(28'h10), 1'b1, data, data[7:4]));
            wait_idle();
            check_gpio();
            issue_access(1 - i % 2, make_req(platform_addr(28'h10), 1'b0, '0, '0));
            wait_idle();
        end
    endtask

    task automatic write_compare(input logic [27:0] off, input logic [31:0] value);
        issue_access(1, make_req(platform_addr(off), 1'b1, value, 4'hF));
        wait_idle();
        check_interrupt();
    endtask

    task automatic timer_compare();
        ticks_left = TICKS;
        tick_total = tick_total + TICKS;
        // Last tick has to reach the timer first
        while (ticks_left != 0 || mtime_tick) begin
            @(negedge clk);
        end
        issue_access(1, make_req(platform_addr(28'h00), 1'b0, '0, '0));
        issue_access(0, make_req(platform_addr(28'h04), 1'b0, '0, '0));
        wait_idle();
        write_compare(28'h0C, 32'h0);
        write_compare(28'h08, tick_total[31:0]);
        write_compare(28'h08, tick_total[31:0] - 32'd5);
        write_compare(28'h08, tick_total[31:0] + 32'd1);
        issue_access(0, make_req(platform_addr(28'h08), 1'b0, '0, '0));
        wait_idle();
    endtask

    initial begin
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_gpio();
        check_interrupt();
        sram_fill_check();
        stream_both();
        error_access();
        gpio_write_read();
        timer_compare();
        for (int m = 0; m < 2; m++) begin
            assert (rsp_count[m] == issued_count[m] && sent_count[m] == issued_count[m])
            else begin
                flow_errors++;
                $display("The %s port had %0d requests accepted and %0d responses for %0d issued",
                         master_name(m), sent_count[m], rsp_count[m], issued_count[m]);
            end
        end
        finish_run();
    end

endmodule

//--- filelist.f
+incdir+include
design/soc_pkg.sv
design/bus_slice.sv
design/bus_arbiter.sv
design/soc_sram.sv
design/soc_platform.sv
design/soc_top.sv
verif/soc_tb_clock.sv
verif/soc_bus_checker.sv
verif/soc_tb.sv
